// ==== design/ram_pkg.sv ====
package ram_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// memory geometry.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	// both rams carry the same byte payload.
	localparam int RAM_DATA_WIDTH = 8;

	// true dual-port ram, 1k words.
	localparam int TDP_ADDR_WIDTH = 10;

	// simple dual-port ram, small enough for distributed memory.
	localparam int SDP_ADDR_WIDTH = 4;

	localparam int TDP_DEPTH = 1 << TDP_ADDR_WIDTH;
	localparam int SDP_DEPTH = 1 << SDP_ADDR_WIDTH;

endpackage

// ==== design/exerciser_pkg.sv ====
package exerciser_pkg;
	import ram_pkg::*;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// port requests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef struct packed {
		logic enable;
		logic write;
		logic [TDP_ADDR_WIDTH-1:0] addr;
		logic [RAM_DATA_WIDTH-1:0] idata;
	} tdp_req_t;

	typedef struct packed {
		logic enable;
		logic [SDP_ADDR_WIDTH-1:0] addr;
		logic [RAM_DATA_WIDTH-1:0] data;
	} sdp_wr_t;

	typedef struct packed {
		logic enable;
		logic [SDP_ADDR_WIDTH-1:0] addr;
	} sdp_rd_t;

	// which ram drives the leds.
	typedef enum logic {MODE_TDP, MODE_SDP} mode_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pattern steps.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam logic [TDP_ADDR_WIDTH-1:0] TDP_ADDR1_STEP = TDP_ADDR_WIDTH'(1);
	localparam logic [TDP_ADDR_WIDTH-1:0] TDP_ADDR2_STEP = TDP_ADDR_WIDTH'(3);
	localparam logic [RAM_DATA_WIDTH-1:0] TDP_DATA1_STEP = RAM_DATA_WIDTH'(5);
	localparam logic [RAM_DATA_WIDTH-1:0] TDP_DATA2_OFFSET = RAM_DATA_WIDTH'(7); // on idata1.
	localparam logic [SDP_ADDR_WIDTH-1:0] SDP_WADDR_STEP = SDP_ADDR_WIDTH'(1);
	localparam logic [RAM_DATA_WIDTH-1:0] SDP_WDATA_STEP = RAM_DATA_WIDTH'(3);
	localparam logic [SDP_ADDR_WIDTH-1:0] SDP_RADDR_STEP = SDP_ADDR_WIDTH'(5);

endpackage

// ==== design/mode_button.sv ====
module mode_button
	import exerciser_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 16
)
(
	input  logic  clock,
	input  logic  resetn,
	input  logic  mode_pin,
	output mode_t mode
);

	localparam int CNT_WIDTH = $clog2(DEBOUNCE_CYCLES + 1);
	localparam logic [CNT_WIDTH-1:0] CNT_LAST = CNT_WIDTH'(DEBOUNCE_CYCLES - 1);

	logic sync1;
	logic sync2;
	logic level; // accepted pin level.
	logic [CNT_WIDTH-1:0] count;

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			sync1 <= 1'b0;
			sync2 <= 1'b0;
		end
		else
		begin
			sync1 <= mode_pin;
			sync2 <= sync1;
		end
	end

	// count samples that differ from the accepted level.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			level <= 1'b0;
			count <= '0;
			mode  <= MODE_TDP;
		end
		else if (sync2 == level)
			count <= '0; // glitch ended early.
		else if (count == CNT_LAST)
		begin
			level <= sync2;
			count <= '0;
			if (sync2)
				mode <= (mode == MODE_TDP) ? MODE_SDP : MODE_TDP; // press.
		end
		else
			count <= count + 1'b1;
	end

endmodule

// ==== design/pattern_generator.sv ====
module pattern_generator
	import ram_pkg::*;
	import exerciser_pkg::*;
(
	input  logic     clock,
	input  logic     resetn,
	output tdp_req_t tdp_req1,
	output tdp_req_t tdp_req2,
	output sdp_wr_t  sdp_wr,
	output sdp_rd_t  sdp_rd
);

	logic [TDP_ADDR_WIDTH-1:0] addr1;
	logic [TDP_ADDR_WIDTH-1:0] addr2;
	logic [RAM_DATA_WIDTH-1:0] idata1;
	logic [RAM_DATA_WIDTH-1:0] idata2;
	logic [3:0] tdp_control;

	logic [SDP_ADDR_WIDTH-1:0] waddr;
	logic [RAM_DATA_WIDTH-1:0] wdata;
	logic [SDP_ADDR_WIDTH-1:0] raddr;
	logic [1:0] sdp_control;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// true dual-port stream.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			addr1       <= '0;
			addr2       <= '0;
			idata1      <= '0;
			idata2      <= '0;
			tdp_control <= '0;
		end
		else
		begin
			addr1       <= addr1 + TDP_ADDR1_STEP;
			addr2       <= addr2 + TDP_ADDR2_STEP;
			idata1      <= idata1 + TDP_DATA1_STEP;
			idata2      <= idata1 + TDP_DATA2_OFFSET; // trails idata1 by a cycle.
			tdp_control <= tdp_control + 4'd1;
		end
	end

	assign tdp_req1 = '{
		enable: tdp_control[0],
		write:  tdp_control[1],
		addr:   addr1,
		idata:  idata1
	};

	assign tdp_req2 = '{
		enable: tdp_control[2],
		write:  tdp_control[3],
		addr:   addr2,
		idata:  idata2
	};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// simple dual-port stream.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
		begin
			waddr       <= '0;
			wdata       <= '0;
			raddr       <= '0;
			sdp_control <= '0;
		end
		else
		begin
			waddr       <= waddr + SDP_WADDR_STEP;
			wdata       <= wdata + SDP_WDATA_STEP;
			raddr       <= raddr + SDP_RADDR_STEP;
			sdp_control <= sdp_control + 2'd1;
		end
	end

	assign sdp_wr = '{enable: sdp_control[0], addr: waddr, data: wdata};
	assign sdp_rd = '{enable: sdp_control[1], addr: raddr};

endmodule

// ==== design/true_dual_port_ram_writefirst_reg1.sv ====
module true_dual_port_ram_writefirst_reg1
#(
	parameter int DATA_WIDTH = 8,
	parameter int ADDR_WIDTH = 10
)
(
	input  logic                  clock1,
	input  logic                  enable1,
	input  logic                  write1,
	input  logic [ADDR_WIDTH-1:0] addr1,
	input  logic [DATA_WIDTH-1:0] idata1,
	output logic [DATA_WIDTH-1:0] odata1,

	input  logic                  clock2,
	input  logic                  enable2,
	input  logic                  write2,
	input  logic [ADDR_WIDTH-1:0] addr2,
	input  logic [DATA_WIDTH-1:0] idata2,
	output logic [DATA_WIDTH-1:0] odata2
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	logic [DATA_WIDTH-1:0] latch1;
	logic [DATA_WIDTH-1:0] latch2;
	logic collide;

	// port 2 takes the word when both ports write one address.
	assign collide = enable2 && write2 && (addr2 == addr1);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// port 1.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clock1)
	begin
		if (enable1)
		begin
			if (write1)
			begin
				if (!collide)
					mem[addr1] <= idata1;
				latch1 <= idata1; // write-first.
			end
			else
				latch1 <= mem[addr1];
		end
	end

	always @(posedge clock1)
	begin
		odata1 <= latch1;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// port 2.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clock2)
	begin
		if (enable2)
		begin
			if (write2)
			begin
				mem[addr2] <= idata2;
				latch2 <= idata2;
			end
			else
				latch2 <= mem[addr2]; // old word if port 1 writes here.
		end
	end

	always @(posedge clock2)
	begin
		odata2 <= latch2;
	end

endmodule

// ==== design/simple_dual_port_ram_reg1.sv ====
module simple_dual_port_ram_reg1
#(
	parameter int DATA_WIDTH = 8,
	parameter int ADDR_WIDTH = 4
)
(
	input  logic                  wclock,
	input  logic                  wenable,
	input  logic [ADDR_WIDTH-1:0] waddr,
	input  logic [DATA_WIDTH-1:0] wdata,

	input  logic                  rclock,
	input  logic                  renable,
	input  logic [ADDR_WIDTH-1:0] raddr,
	output logic [DATA_WIDTH-1:0] rdata
);

	localparam int DEPTH = 1 << ADDR_WIDTH;

	logic [DATA_WIDTH-1:0] mem [DEPTH];

	// write side.
	always_ff @(posedge wclock)
	begin
		if (wenable)
			mem[waddr] <= wdata;
	end

	// read side, returns the old word on a same-cycle write.
	always_ff @(posedge rclock)
	begin
		if (renable)
			rdata <= mem[raddr];
	end

endmodule

// ==== design/led_driver.sv ====
module led_driver
	import ram_pkg::*;
	import exerciser_pkg::*;
(
	input  logic                      clock,
	input  logic                      resetn,
	input  mode_t                     mode,
	input  logic [RAM_DATA_WIDTH-1:0] odata1,
	input  logic [RAM_DATA_WIDTH-1:0] odata2,
	input  logic [RAM_DATA_WIDTH-1:0] rdata,
	output logic [7:0]                leds
);

	logic [RAM_DATA_WIDTH-1:0] sum;

	// fold both true dual-port outputs into one byte.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			sum <= '0;
		else
			sum <= odata1 + odata2; // wraps.
	end

	// leds are active low.
	always_ff @(posedge clock or negedge resetn)
	begin
		if (!resetn)
			leds <= 8'haa;
		else if (mode == MODE_TDP)
			leds <= ~sum;
		else
			leds <= ~rdata;
	end

endmodule

// ==== design/ram_exerciser.sv ====
module ram_exerciser
	import ram_pkg::*;
	import exerciser_pkg::*;
#(
	parameter int DEBOUNCE_CYCLES = 16
)
(
	input  logic       clock,
	input  logic       resetn,
	input  logic       mode_pin,
	output logic [7:0] leds
);

	mode_t    mode;
	tdp_req_t tdp_req1;
	tdp_req_t tdp_req2;
	sdp_wr_t  sdp_wr;
	sdp_rd_t  sdp_rd;

	logic [RAM_DATA_WIDTH-1:0] odata1;
	logic [RAM_DATA_WIDTH-1:0] odata2;
	logic [RAM_DATA_WIDTH-1:0] rdata;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// input side.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	mode_button #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) mode_button_inst (
		.clock    (clock),
		.resetn   (resetn),
		.mode_pin (mode_pin),
		.mode     (mode)
	);

	pattern_generator pattern_generator_inst (
		.clock    (clock),
		.resetn   (resetn),
		.tdp_req1 (tdp_req1),
		.tdp_req2 (tdp_req2),
		.sdp_wr   (sdp_wr),
		.sdp_rd   (sdp_rd)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// rams, both on the one clock.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	true_dual_port_ram_writefirst_reg1 #(
		.DATA_WIDTH (RAM_DATA_WIDTH),
		.ADDR_WIDTH (TDP_ADDR_WIDTH)
	) tdp_ram_inst (
		.clock1  (clock),
		.enable1 (tdp_req1.enable),
		.write1  (tdp_req1.write),
		.addr1   (tdp_req1.addr),
		.idata1  (tdp_req1.idata),
		.odata1  (odata1),
		.clock2  (clock),
		.enable2 (tdp_req2.enable),
		.write2  (tdp_req2.write),
		.addr2   (tdp_req2.addr),
		.idata2  (tdp_req2.idata),
		.odata2  (odata2)
	);

	simple_dual_port_ram_reg1 #(
		.DATA_WIDTH (RAM_DATA_WIDTH),
		.ADDR_WIDTH (SDP_ADDR_WIDTH)
	) sdp_ram_inst (
		.wclock  (clock),
		.wenable (sdp_wr.enable),
		.waddr   (sdp_wr.addr),
		.wdata   (sdp_wr.data),
		.rclock  (clock),
		.renable (sdp_rd.enable),
		.raddr   (sdp_rd.addr),
		.rdata   (rdata)
	);

	// output side.
	led_driver led_driver_inst (
		.clock  (clock),
		.resetn (resetn),
		.mode   (mode),
		.odata1 (odata1),
		.odata2 (odata2),
		.rdata  (rdata),
		.leds   (leds)
	);

endmodule

// ==== verification/tb_ram_exerciser.sv ====
module tb_ram_exerciser
	import ram_pkg::*;
	import exerciser_pkg::*;
();

	localparam int DEBOUNCE_CYCLES = 8;
	localparam int SWITCH_EDGES = 2 + DEBOUNCE_CYCLES; // pin change to mode change.
	localparam int MAX_CYCLES = 6000;

	// a byte of the reference model and whether its value is known.
	typedef struct packed {
		logic [RAM_DATA_WIDTH-1:0] value;
		logic known;
	} model_byte_t;

	logic clock;
	logic resetn;
	logic mode_pin;
	logic [7:0] leds;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// reference model state.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	logic [TDP_ADDR_WIDTH-1:0] m_addr1;
	logic [TDP_ADDR_WIDTH-1:0] m_addr2;
	logic [RAM_DATA_WIDTH-1:0] m_idata1;
	logic [RAM_DATA_WIDTH-1:0] m_idata2;
	logic [3:0] m_tctl;
	logic [SDP_ADDR_WIDTH-1:0] m_waddr;
	logic [RAM_DATA_WIDTH-1:0] m_wdata;
	logic [SDP_ADDR_WIDTH-1:0] m_raddr;
	logic [1:0] m_sctl;

	model_byte_t tdp_mem [TDP_DEPTH];
	model_byte_t sdp_mem [SDP_DEPTH];
	model_byte_t lat1;
	model_byte_t lat2;
	model_byte_t od1;
	model_byte_t od2;
	model_byte_t sum;
	model_byte_t rd;
	model_byte_t leds_exp;
	mode_t m_mode;
	int toggle_at; // edge at which the model mode flips.
	int edges;

	int cycles;
	int errors;
	int compares;
	int passed;
	int failed;
	logic [31:0] lfsr;

	ram_exerciser #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES)) DUT (
		.clock    (clock),
		.resetn   (resetn),
		.mode_pin (mode_pin),
		.leds     (leds)
	);

	initial
	begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout, the run went past %0d cycles", MAX_CYCLES);
			$display("Result: FAILED");
			$finish;
		end
	end

	always @(posedge clock)
		step_model();

	function automatic model_byte_t known_byte(input logic [RAM_DATA_WIDTH-1:0] value);
		model_byte_t b;
		b.value = value;
		b.known = 1'b1;
		return b;
	endfunction

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'hd000_0001;
		return n;
	endfunction

	// only registers with a reset go back, the ram words stay.
	task automatic clear_model();
		m_addr1 = '0;
		m_addr2 = '0;
		m_idata1 = '0;
		m_idata2 = '0;
		m_tctl = '0;
		m_waddr = '0;
		m_wdata = '0;
		m_raddr = '0;
		m_sctl = '0;
		sum = known_byte(8'h00);
		leds_exp = known_byte(8'haa);
		m_mode = MODE_TDP;
		toggle_at = -1;
	endtask

	// the output side steps first and sees last cycle's values.
	task automatic step_model();
		model_byte_t r1;
		model_byte_t r2;
		edges++;
		if (resetn)
		begin
			leds_exp.value = (m_mode == MODE_TDP) ? ~sum.value : ~rd.value;
			leds_exp.known = (m_mode == MODE_TDP) ? sum.known : rd.known;
			sum.value = od1.value + od2.value; // modulo 256.
			sum.known = od1.known && od2.known;
		end
		od1 = lat1;
		od2 = lat2;
		r1 = tdp_mem[m_addr1]; // reads see the old words.
		r2 = tdp_mem[m_addr2];
		if (m_tctl[0])
			lat1 = m_tctl[1] ? known_byte(m_idata1) : r1;
		if (m_tctl[2])
			lat2 = m_tctl[3] ? known_byte(m_idata2) : r2;
		if (m_tctl[0] && m_tctl[1])
			tdp_mem[m_addr1] = known_byte(m_idata1);
		if (m_tctl[2] && m_tctl[3])
			tdp_mem[m_addr2] = known_byte(m_idata2); // port 2 goes last and wins.
		if (m_sctl[1])
			rd = sdp_mem[m_raddr];
		if (m_sctl[0])
			sdp_mem[m_waddr] = known_byte(m_wdata);
		if (resetn)
		begin
			m_addr1 = m_addr1 + 10'd1;
			m_addr2 = m_addr2 + 10'd3;
			m_idata2 = m_idata1 + 8'd7;
			m_idata1 = m_idata1 + 8'd5;
			m_tctl = m_tctl + 4'd1;
			m_waddr = m_waddr + 4'd1;
			m_wdata = m_wdata + 8'd3;
			m_raddr = m_raddr + 4'd5;
			m_sctl = m_sctl + 2'd1;
			if (edges == toggle_at)
				m_mode = (m_mode == MODE_TDP) ? MODE_SDP : MODE_TDP;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// stimulus and compare helpers.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic hold_reset(input int n);
		repeat (n)
		begin
			@(posedge clock);
			#2;
			if (leds !== 8'haa)
			begin
				errors++;
				$display("[FAIL] leds: got %h, expected %h in reset", leds, 8'haa);
			end
		end
		resetn = 1'b1;
		@(negedge clock); // still before the first edge after release.
		if (leds !== 8'haa)
		begin
			errors++;
			$display("[FAIL] leds: got %h, expected %h after release", leds, 8'haa);
		end
	endtask

	task automatic set_pin(input logic value, input logic toggles);
		@(posedge clock);
		#2;
		mode_pin = value;
		if (toggles)
			toggle_at = edges + SWITCH_EDGES;
	endtask

	task automatic follow_leds(input int n);
		repeat (n)
		begin
			@(negedge clock);
			if (DUT.mode !== m_mode)
			begin
				errors++;
				$display("[FAIL] mode: got %h, expected %h at cycle %0d",
					DUT.mode, m_mode, cycles);
			end
			if (leds_exp.known)
			begin
				compares++;
				if (leds !== leds_exp.value)
				begin
					errors++;
					$display("[FAIL] leds: got %h, expected %h at cycle %0d",
						leds, leds_exp.value, cycles);
				end
			end
		end
	endtask

	task automatic close_check(input string name, input int err0, input int cmp0,
		input logic need_cmp);
		if (need_cmp && compares == cmp0)
		begin
			errors++;
			$display("%s: the model never had a known leds value to compare", name);
		end
		if (errors == err0)
		begin
			passed++;
			$display("%s: ok", name);
		end
		else
		begin
			failed++;
			$display("%s: %0d errors", name, errors - err0);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// directed tests.
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	task automatic reset_holds_pattern();
		int err0;
		err0 = errors;
		hold_reset(2);
		close_check("reset value", err0, compares, 1'b0);
	endtask

	task automatic tdp_stream_matches();
		int err0;
		int cmp0;
		err0 = errors;
		cmp0 = compares;
		follow_leds(600);
		close_check("tdp stream", err0, cmp0, 1'b1);
	endtask

	task automatic press_selects_sdp();
		int err0;
		int cmp0;
		err0 = errors;
		cmp0 = compares;
		set_pin(1'b1, 1'b1);
		follow_leds(SWITCH_EDGES + 300);
		set_pin(1'b0, 1'b0); // release is accepted without a toggle.
		follow_leds(20);
		close_check("press to sdp", err0, cmp0, 1'b1);
	endtask

	task automatic glitches_are_ignored();
		int err0;
		int cmp0;
		int len;
		logic [2:0] bits;
		err0 = errors;
		cmp0 = compares;
		bits = '0;
		repeat (6)
		begin
			repeat (3)
			begin
				lfsr = lfsr_step(lfsr);
				bits = {bits[1:0], lfsr[0]};
			end
			len = 1 + bits % 7;
			set_pin(1'b1, 1'b0);
			follow_leds(len); // pin is sampled high on len edges.
			set_pin(1'b0, 1'b0);
			follow_leds(12);
		end
		close_check("short glitches", err0, cmp0, 1'b1);
	endtask

	task automatic second_press_returns();
		int err0;
		int cmp0;
		err0 = errors;
		cmp0 = compares;
		set_pin(1'b1, 1'b1);
		follow_leds(SWITCH_EDGES + 40);
		set_pin(1'b0, 1'b0);
		follow_leds(20);
		close_check("press to tdp", err0, cmp0, 1'b1);
	endtask

	task automatic midrun_reset_restarts();
		int err0;
		int cmp0;
		err0 = errors;
		cmp0 = compares;
		set_pin(1'b1, 1'b1); // go to sdp first so the reset has a mode to undo.
		follow_leds(SWITCH_EDGES + 10);
		set_pin(1'b0, 1'b0);
		follow_leds(15);
		@(posedge clock);
		#2;
		resetn = 1'b0;
		clear_model();
		hold_reset(2);
		follow_leds(200);
		close_check("mid-run reset", err0, cmp0, 1'b1);
	endtask

	initial
	begin
		resetn = 1'b0;
		mode_pin = 1'b0;
		lfsr = 32'h20df_4c08;
		cycles = 0;
		edges = 0;
		errors = 0;
		compares = 0;
		passed = 0;
		failed = 0;
		foreach (tdp_mem[i])
			tdp_mem[i] = '0;
		foreach (sdp_mem[i])
			sdp_mem[i] = '0;
		lat1 = '0;
		lat2 = '0;
		od1 = '0;
		od2 = '0;
		rd = '0;
		clear_model();

		reset_holds_pattern();
		tdp_stream_matches();
		press_selects_sdp();
		glitches_are_ignored();
		second_press_returns();
		midrun_reset_restarts();

		$display("checks: %0d passed, %0d failed, %0d leds compares, %0d errors",
			passed, failed, compares, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== vlog.f ====
design/ram_pkg.sv
design/exerciser_pkg.sv
design/mode_button.sv
design/pattern_generator.sv
design/true_dual_port_ram_writefirst_reg1.sv
design/simple_dual_port_ram_reg1.sv
design/led_driver.sv
design/ram_exerciser.sv
verification/tb_ram_exerciser.sv
